/* design/cpu_isa_pkg.sv */
`default_nettype none

package cpu_isa_pkg;

    localparam int word_size = 16;

    typedef logic [1:0] reg_idx_t;

    typedef enum logic [3:0] {
        op_bne   = 4'd0,
        op_beq   = 4'd1,
        op_adi   = 4'd4,
        op_lhi   = 4'd6,
        op_lwd   = 4'd7,
        op_swd   = 4'd8,
        op_jmp   = 4'd9,
        op_rtype = 4'd15
    } opcode_t;

    // r-type function field
    localparam logic [5:0] fn_add = 6'd0;
    localparam logic [5:0] fn_sub = 6'd1;
    localparam logic [5:0] fn_and = 6'd2;
    localparam logic [5:0] fn_orr = 6'd3;
    localparam logic [5:0] fn_wwd = 6'd28;
    localparam logic [5:0] fn_hlt = 6'd29;

    typedef struct packed {
        opcode_t    opcode;
        reg_idx_t   rs;
        reg_idx_t   rt;
        reg_idx_t   rd;
        logic [5:0] func;
    } r_format_t;

    typedef struct packed {
        opcode_t           opcode;
        reg_idx_t          rs;
        reg_idx_t          rt;
        logic signed [7:0] imm;
    } i_format_t;

    // jmp takes bits 11:0 of the raw word
    typedef union packed {
        r_format_t r;
        i_format_t i;
    } instr_t;

endpackage

`default_nettype wire

/* design/cpu_pipe_pkg.sv */
`default_nettype none

package cpu_pipe_pkg;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_pass_b   // lhi
    } alu_op_t;

    typedef enum logic {
        pc_seq,
        pc_target
    } pc_src_t;

    localparam logic [cpu_isa_pkg::word_size-1:0] reset_pc = '0;

endpackage

`default_nettype wire

/* design/cpu_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_pipeline import cpu_isa_pkg::*, cpu_pipe_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    output logic                 inst_read,
    output logic [word_size-1:0] inst_addr,
    input  logic [word_size-1:0] inst_data,
    output logic                 data_read,
    output logic                 data_write,
    output logic [word_size-1:0] data_addr,
    output logic [word_size-1:0] data_wdata,
    input  logic [word_size-1:0] data_rdata,
    output logic [word_size-1:0] output_port,
    output logic                 output_valid,
    output logic [word_size-1:0] num_inst,
    output logic                 halted
);

    // fetch/decode
    logic                 fd_valid;
    logic [word_size-1:0] fd_pc;
    logic [word_size-1:0] fd_instr;

    // back-channels
    logic                 stall;
    logic                 halt_seen;
    logic                 redirect;
    logic [word_size-1:0] redirect_pc;
    logic                 ex_dest_valid;
    reg_idx_t             ex_dest;
    logic                 mem_dest_valid;
    reg_idx_t             mem_dest;
    logic                 reg_write;
    reg_idx_t             reg_waddr;
    logic [word_size-1:0] reg_wdata;

    // decode/execute
    logic                 de_valid;
    logic [word_size-1:0] de_pc;
    logic [word_size-1:0] de_a;
    logic [word_size-1:0] de_b;
    logic [word_size-1:0] de_imm;
    alu_op_t              de_alu_op;
    logic                 de_use_imm;
    logic                 de_is_branch;
    logic                 de_branch_eq;
    logic                 de_is_jump;
    logic [11:0]          de_jump_target;
    logic                 de_mem_read;
    logic                 de_mem_write;
    logic                 de_reg_write;
    reg_idx_t             de_dest;
    logic                 de_is_wwd;
    logic                 de_is_halt;

    // execute/memory
    logic                 em_valid;
    logic [word_size-1:0] em_result;
    logic [word_size-1:0] em_store_data;
    logic                 em_mem_read;
    logic                 em_mem_write;
    logic                 em_reg_write;
    reg_idx_t             em_dest;
    logic                 em_is_wwd;
    logic [word_size-1:0] em_is_wwd_value;
    logic                 em_is_halt;

    // memory/writeback
    logic                 mw_valid;
    logic [word_size-1:0] mw_result;
    logic                 mw_reg_write;
    reg_idx_t             mw_dest;
    logic                 mw_is_wwd;
    logic [word_size-1:0] mw_wwd_value;
    logic                 mw_is_halt;

    fetch_stage fetch_i (
        .clk, .reset, .stall, .redirect, .redirect_pc, .halt_seen,
        .inst_read, .inst_addr, .inst_data,
        .fd_valid, .fd_pc, .fd_instr
    );

    decode_stage decode_i (
        .clk, .reset, .fd_valid, .fd_pc, .fd_instr,
        .flush(redirect),   // taken branch or jump in execute
        .ex_dest_valid, .ex_dest, .mem_dest_valid, .mem_dest,
        .reg_write, .reg_waddr, .reg_wdata,
        .stall, .halt_seen,
        .de_valid, .de_pc, .de_a, .de_b, .de_imm, .de_alu_op, .de_use_imm,
        .de_is_branch, .de_branch_eq, .de_is_jump, .de_jump_target,
        .de_mem_read, .de_mem_write, .de_reg_write, .de_dest,
        .de_is_wwd, .de_is_halt
    );

    execute_stage execute_i (
        .clk, .reset,
        .de_valid, .de_pc, .de_a, .de_b, .de_imm, .de_alu_op, .de_use_imm,
        .de_is_branch, .de_branch_eq, .de_is_jump, .de_jump_target,
        .de_mem_read, .de_mem_write, .de_reg_write, .de_dest,
        .de_is_wwd, .de_is_halt,
        .redirect, .redirect_pc, .ex_dest_valid, .ex_dest,
        .em_valid, .em_result, .em_store_data, .em_mem_read, .em_mem_write,
        .em_reg_write, .em_dest, .em_is_wwd, .em_is_wwd_value, .em_is_halt
    );

    memory_stage memory_i (
        .clk, .reset,
        .em_valid, .em_result, .em_store_data, .em_mem_read, .em_mem_write,
        .em_reg_write, .em_dest, .em_is_wwd, .em_is_wwd_value, .em_is_halt,
        .data_read, .data_write, .data_addr, .data_wdata, .data_rdata,
        .mem_dest_valid, .mem_dest,
        .mw_valid, .mw_result, .mw_reg_write, .mw_dest,
        .mw_is_wwd, .mw_wwd_value, .mw_is_halt
    );

    writeback_stage writeback_i (
        .clk, .reset,
        .mw_valid, .mw_result, .mw_reg_write, .mw_dest,
        .mw_is_wwd, .mw_wwd_value, .mw_is_halt,
        .reg_write, .reg_waddr, .reg_wdata,
        .output_port, .output_valid, .num_inst, .halted
    );

endmodule

`default_nettype wire

/* design/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage import cpu_isa_pkg::*, cpu_pipe_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 fd_valid,
    input  logic [word_size-1:0] fd_pc,
    input  logic [word_size-1:0] fd_instr,
    input  logic                 flush,
    input  logic                 ex_dest_valid,
    input  reg_idx_t             ex_dest,
    input  logic                 mem_dest_valid,
    input  reg_idx_t             mem_dest,
    input  logic                 reg_write,
    input  reg_idx_t             reg_waddr,
    input  logic [word_size-1:0] reg_wdata,
    output logic                 stall,
    output logic                 halt_seen,
    output logic                 de_valid,
    output logic [word_size-1:0] de_pc,
    output logic [word_size-1:0] de_a,
    output logic [word_size-1:0] de_b,
    output logic [word_size-1:0] de_imm,
    output alu_op_t              de_alu_op,
    output logic                 de_use_imm,
    output logic                 de_is_branch,
    output logic                 de_branch_eq,
    output logic                 de_is_jump,
    output logic [11:0]          de_jump_target,
    output logic                 de_mem_read,
    output logic                 de_mem_write,
    output logic                 de_reg_write,
    output reg_idx_t             de_dest,
    output logic                 de_is_wwd,
    output logic                 de_is_halt
);

    instr_t               ins;
    logic [word_size-1:0] regs [4];
    logic [word_size-1:0] rs_val;
    logic [word_size-1:0] rt_val;
    logic [word_size-1:0] imm_ext;
    logic                 uses_rs;
    logic                 uses_rt;
    logic                 rs_busy;
    logic                 rt_busy;
    logic                 halt_q;
    alu_op_t              dec_alu_op;
    logic                 dec_use_imm;
    logic                 dec_is_branch;
    logic                 dec_branch_eq;
    logic                 dec_is_jump;
    logic                 dec_mem_read;
    logic                 dec_mem_write;
    logic                 dec_reg_write;
    reg_idx_t             dec_dest;
    logic                 dec_is_wwd;
    logic                 dec_is_halt;

    assign ins = fd_instr;

    always_ff @(posedge clk) begin
        if (reg_write)
            regs[reg_waddr] <= reg_wdata;
    end

    // same-cycle writeback is seen by the read
    assign rs_val = (reg_write && reg_waddr == ins.r.rs) ? reg_wdata : regs[ins.r.rs];
    assign rt_val = (reg_write && reg_waddr == ins.r.rt) ? reg_wdata : regs[ins.r.rt];

    assign imm_ext = (ins.i.opcode == op_lhi) ? {ins.i.imm, 8'h00}
                                              : {{8{ins.i.imm[7]}}, ins.i.imm};

    always_comb begin
        dec_alu_op    = alu_add;
        dec_use_imm   = 1'b0;
        dec_is_branch = 1'b0;
        dec_branch_eq = 1'b0;
        dec_is_jump   = 1'b0;
        dec_mem_read  = 1'b0;
        dec_mem_write = 1'b0;
        dec_reg_write = 1'b0;
        dec_dest      = ins.i.rt;
        dec_is_wwd    = 1'b0;
        dec_is_halt   = 1'b0;
        uses_rs       = 1'b0;
        uses_rt       = 1'b0;
        case (ins.r.opcode)
            op_rtype: begin
                dec_dest = ins.r.rd;
                uses_rs  = 1'b1;
                case (ins.r.func)
                    fn_add, fn_sub, fn_and, fn_orr: begin
                        dec_reg_write = 1'b1;
                        uses_rt       = 1'b1;
                    end
                    fn_wwd: dec_is_wwd = 1'b1;
                    fn_hlt: begin
                        dec_is_halt = 1'b1;
                        uses_rs     = 1'b0;
                    end
                    default: uses_rs = 1'b0;
                endcase
                case (ins.r.func)
                    fn_sub:  dec_alu_op = alu_sub;
                    fn_and:  dec_alu_op = alu_and;
                    fn_orr:  dec_alu_op = alu_or;
                    default: dec_alu_op = alu_add;
                endcase
            end
            op_adi: begin
                dec_reg_write = 1'b1;
                dec_use_imm   = 1'b1;
                uses_rs       = 1'b1;
            end
            op_lhi: begin
                dec_reg_write = 1'b1;
                dec_use_imm   = 1'b1;
                dec_alu_op    = alu_pass_b;
            end
            op_lwd: begin
                dec_reg_write = 1'b1;
                dec_use_imm   = 1'b1;
                dec_mem_read  = 1'b1;
                uses_rs       = 1'b1;
            end
            op_swd: begin
                dec_use_imm   = 1'b1;
                dec_mem_write = 1'b1;
                uses_rs       = 1'b1;
                uses_rt       = 1'b1;   // store data
            end
            op_bne, op_beq: begin
                dec_is_branch = 1'b1;
                dec_branch_eq = (ins.r.opcode == op_beq);
                uses_rs       = 1'b1;
                uses_rt       = 1'b1;
            end
            op_jmp: dec_is_jump = 1'b1;
            default: ;
        endcase
    end

    // interlock against writers still in execute or memory
    assign rs_busy = (ex_dest_valid && ex_dest == ins.r.rs) ||
                     (mem_dest_valid && mem_dest == ins.r.rs);
    assign rt_busy = (ex_dest_valid && ex_dest == ins.r.rt) ||
                     (mem_dest_valid && mem_dest == ins.r.rt);
    assign stall   = fd_valid && ((uses_rs && rs_busy) || (uses_rt && rt_busy));

    assign halt_seen = halt_q || (fd_valid && dec_is_halt);

    always_ff @(posedge clk) begin
        if (reset) begin
            de_valid <= 1'b0;
            halt_q   <= 1'b0;
        end else begin
            de_valid <= fd_valid && !stall && !flush;   // bubble on stall
            if (fd_valid && dec_is_halt && !flush)
                halt_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        de_pc          <= fd_pc;
        de_a           <= rs_val;
        de_b           <= rt_val;
        de_imm         <= imm_ext;
        de_alu_op      <= dec_alu_op;
        de_use_imm     <= dec_use_imm;
        de_is_branch   <= dec_is_branch;
        de_branch_eq   <= dec_branch_eq;
        de_is_jump     <= dec_is_jump;
        de_jump_target <= fd_instr[11:0];
        de_mem_read    <= dec_mem_read;
        de_mem_write   <= dec_mem_write;
        de_reg_write   <= dec_reg_write;
        de_dest        <= dec_dest;
        de_is_wwd      <= dec_is_wwd;
        de_is_halt     <= dec_is_halt;
    end

endmodule

`default_nettype wire

/* design/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage import cpu_isa_pkg::*, cpu_pipe_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 de_valid,
    input  logic [word_size-1:0] de_pc,
    input  logic [word_size-1:0] de_a,
    input  logic [word_size-1:0] de_b,
    input  logic [word_size-1:0] de_imm,
    input  alu_op_t              de_alu_op,
    input  logic                 de_use_imm,
    input  logic                 de_is_branch,
    input  logic                 de_branch_eq,
    input  logic                 de_is_jump,
    input  logic [11:0]          de_jump_target,
    input  logic                 de_mem_read,
    input  logic                 de_mem_write,
    input  logic                 de_reg_write,
    input  reg_idx_t             de_dest,
    input  logic                 de_is_wwd,
    input  logic                 de_is_halt,
    output logic                 redirect,
    output logic [word_size-1:0] redirect_pc,
    output logic                 ex_dest_valid,
    output reg_idx_t             ex_dest,
    output logic                 em_valid,
    output logic [word_size-1:0] em_result,
    output logic [word_size-1:0] em_store_data,
    output logic                 em_mem_read,
    output logic                 em_mem_write,
    output logic                 em_reg_write,
    output reg_idx_t             em_dest,
    output logic                 em_is_wwd,
    output logic [word_size-1:0] em_is_wwd_value,
    output logic                 em_is_halt
);

    logic [word_size-1:0] alu_b;
    logic [word_size-1:0] alu_y;
    logic                 taken;

    assign alu_b = de_use_imm ? de_imm : de_b;

    always_comb begin
        case (de_alu_op)
            alu_add:    alu_y = de_a + alu_b;
            alu_sub:    alu_y = de_a - alu_b;
            alu_and:    alu_y = de_a & alu_b;
            alu_or:     alu_y = de_a | alu_b;
            alu_pass_b: alu_y = alu_b;
            default:    alu_y = '0;
        endcase
    end

    assign taken       = de_is_branch && ((de_a == de_b) == de_branch_eq);
    assign redirect    = de_valid && (taken || de_is_jump);
    assign redirect_pc = de_is_jump ? {de_pc[word_size-1:12], de_jump_target}
                                    : de_pc + 1'b1 + de_imm;

    assign ex_dest_valid = de_valid && de_reg_write;
    assign ex_dest       = de_dest;

    always_ff @(posedge clk) begin
        if (reset)
            em_valid <= 1'b0;
        else
            em_valid <= de_valid;
    end

    always_ff @(posedge clk) begin
        em_result       <= alu_y;   // also the load/store address
        em_store_data   <= de_b;
        em_mem_read     <= de_mem_read;
        em_mem_write    <= de_mem_write;
        em_reg_write    <= de_reg_write;
        em_dest         <= de_dest;
        em_is_wwd       <= de_is_wwd;
        em_is_wwd_value <= de_a;
        em_is_halt      <= de_is_halt;
    end

endmodule

`default_nettype wire

/* design/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import cpu_isa_pkg::*, cpu_pipe_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 stall,
    input  logic                 redirect,
    input  logic [word_size-1:0] redirect_pc,
    input  logic                 halt_seen,
    output logic                 inst_read,
    output logic [word_size-1:0] inst_addr,
    input  logic [word_size-1:0] inst_data,
    output logic                 fd_valid,
    output logic [word_size-1:0] fd_pc,
    output logic [word_size-1:0] fd_instr
);

    logic [word_size-1:0] pc;
    logic                 active;   // set once reset is released
    logic                 advance;
    pc_src_t              pc_src;

    assign pc_src    = redirect ? pc_target : pc_seq;
    assign inst_read = active && !halt_seen;
    assign inst_addr = pc;
    assign advance   = inst_read && !stall && (pc_src == pc_seq);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= reset_pc;
            active   <= 1'b0;
            fd_valid <= 1'b0;
        end else begin
            active <= 1'b1;
            if (pc_src == pc_target) begin
                pc       <= redirect_pc;
                fd_valid <= 1'b0;   // wrong-path fetch dropped
            end else if (advance) begin
                pc       <= pc + 1'b1;
                fd_valid <= 1'b1;
            end else if (!stall) begin
                fd_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            fd_pc    <= pc;
            fd_instr <= inst_data;
        end
    end

endmodule

`default_nettype wire

/* design/memory_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_stage import cpu_isa_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 em_valid,
    input  logic [word_size-1:0] em_result,
    input  logic [word_size-1:0] em_store_data,
    input  logic                 em_mem_read,
    input  logic                 em_mem_write,
    input  logic                 em_reg_write,
    input  reg_idx_t             em_dest,
    input  logic                 em_is_wwd,
    input  logic [word_size-1:0] em_is_wwd_value,
    input  logic                 em_is_halt,
    output logic                 data_read,
    output logic                 data_write,
    output logic [word_size-1:0] data_addr,
    output logic [word_size-1:0] data_wdata,
    input  logic [word_size-1:0] data_rdata,
    output logic                 mem_dest_valid,
    output reg_idx_t             mem_dest,
    output logic                 mw_valid,
    output logic [word_size-1:0] mw_result,
    output logic                 mw_reg_write,
    output reg_idx_t             mw_dest,
    output logic                 mw_is_wwd,
    output logic [word_size-1:0] mw_wwd_value,
    output logic                 mw_is_halt
);

    assign data_read  = em_valid && em_mem_read;
    assign data_write = em_valid && em_mem_write;
    assign data_addr  = (data_read || data_write) ? em_result : '0;
    assign data_wdata = data_write ? em_store_data : '0;

    assign mem_dest_valid = em_valid && em_reg_write;
    assign mem_dest       = em_dest;

    always_ff @(posedge clk) begin
        if (reset)
            mw_valid <= 1'b0;
        else
            mw_valid <= em_valid;
    end

    always_ff @(posedge clk) begin
        mw_result    <= em_mem_read ? data_rdata : em_result;
        mw_reg_write <= em_reg_write;
        mw_dest      <= em_dest;
        mw_is_wwd    <= em_is_wwd;
        mw_wwd_value <= em_is_wwd_value;
        mw_is_halt   <= em_is_halt;
    end

endmodule

`default_nettype wire

/* design/writeback_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module writeback_stage import cpu_isa_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 mw_valid,
    input  logic [word_size-1:0] mw_result,
    input  logic                 mw_reg_write,
    input  reg_idx_t             mw_dest,
    input  logic                 mw_is_wwd,
    input  logic [word_size-1:0] mw_wwd_value,
    input  logic                 mw_is_halt,
    output logic                 reg_write,
    output reg_idx_t             reg_waddr,
    output logic [word_size-1:0] reg_wdata,
    output logic [word_size-1:0] output_port,
    output logic                 output_valid,
    output logic [word_size-1:0] num_inst,
    output logic                 halted
);

    assign reg_write = mw_valid && mw_reg_write;
    assign reg_waddr = mw_dest;
    assign reg_wdata = mw_result;

    assign output_valid = mw_valid && mw_is_wwd;   // one-cycle strobe
    assign output_port  = mw_wwd_value;

    always_ff @(posedge clk) begin
        if (reset) begin
            num_inst <= '0;
            halted   <= 1'b0;
        end else if (mw_valid) begin
            num_inst <= num_inst + 1'b1;
            if (mw_is_halt)
                halted <= 1'b1;   // sticky until reset
        end
    end

endmodule

`default_nettype wire

/* list.f */
design/cpu_isa_pkg.sv
design/cpu_pipe_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/writeback_stage.sv
design/cpu_pipeline.sv
testbench/tb_memory.sv
testbench/tb_cpu_pipeline.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_cpu_pipeline -f list.f -o sim_cpu \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_cpu > sim.log 2>&1 || echo "TEST FAILED" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0

/* testbench/tb_cpu_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_pipeline import cpu_isa_pkg::*; ();

    localparam int num_tests   = 4;
    localparam int cycle_limit = 200 * num_tests;

    logic        clk;
    logic        reset;
    logic        inst_read;
    logic [15:0] inst_addr;
    logic [15:0] inst_data;
    logic        data_read;
    logic        data_write;
    logic [15:0] data_addr;
    logic [15:0] data_wdata;
    logic [15:0] data_rdata;
    logic [15:0] output_port;
    logic        output_valid;
    logic [15:0] num_inst;
    logic        halted;

    integer      seed;
    int          cycles = 0;
    logic [15:0] prog [$];
    logic [15:0] exp_out [$];
    logic [15:0] got_out [$];
    logic [15:0] model_regs [4];
    logic [15:0] stored [logic [15:0]];   // words written by SWD
    int          exp_count;
    int          exp_loads;
    int          got_loads;
    bit          skipping;
    int          skip_left;

    cpu_pipeline cpu_pipeline_i (
        .clk, .reset,
        .inst_read, .inst_addr, .inst_data,
        .data_read, .data_write, .data_addr, .data_wdata, .data_rdata,
        .output_port, .output_valid, .num_inst, .halted
    );

    tb_memory mem_i (
        .clk, .inst_addr, .inst_data,
        .data_write, .data_addr, .data_wdata, .data_rdata
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("processor did not halt within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("[ERROR] time %0t: %s is %0h, expected %0h", $time, what, got, expected);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [15:0] fill_word(input logic [15:0] addr);
        return {addr[7:0], addr[15:8]} ^ 16'h5a3c;
    endfunction

    function automatic logic [15:0] sext(input logic [7:0] v);
        return {{8{v[7]}}, v};
    endfunction

    function automatic logic [15:0] r_word(input logic [5:0] func, input int rs, input int rt,
                                           input int rd);
        return {op_rtype, rs[1:0], rt[1:0], rd[1:0], func};
    endfunction

    task automatic start_program();
        prog.delete();
        exp_out.delete();
        stored.delete();
        for (int i = 0; i < 4; i++)
            model_regs[i] = 'x;
        exp_count = 0;
        exp_loads = 0;
        skipping  = 0;
        skip_left = 0;
    endtask

    // stores each emitted word and counts it unless skipped
    task automatic put(input logic [15:0] word);
        prog.push_back(word);
        if (skipping) begin
            skip_left--;
            if (skip_left == 0)
                skipping = 0;
        end else begin
            exp_count++;
        end
    endtask

    task automatic emit_lhi(input int rt, input logic [7:0] imm);
        if (!skipping)
            model_regs[rt] = {imm, 8'h00};
        put({op_lhi, 2'b00, rt[1:0], imm});
    endtask

    task automatic emit_adi(input int rt, input int rs, input logic [7:0] imm);
        if (!skipping)
            model_regs[rt] = model_regs[rs] + sext(imm);
        put({op_adi, rs[1:0], rt[1:0], imm});
    endtask

    // lhi then adi with the high byte corrected for the low byte's sign
    task automatic emit_const(input int r, input logic [15:0] v);
        logic [7:0] hi;
        hi = v[15:8] + {7'b0, v[7]};
        emit_lhi(r, hi);
        emit_adi(r, r, v[7:0]);
    endtask

    task automatic emit_alu(input logic [5:0] func, input int rd, input int rs, input int rt);
        if (!skipping) begin
            case (func)
                fn_add:  model_regs[rd] = model_regs[rs] + model_regs[rt];
                fn_sub:  model_regs[rd] = model_regs[rs] - model_regs[rt];
                fn_and:  model_regs[rd] = model_regs[rs] & model_regs[rt];
                default: model_regs[rd] = model_regs[rs] | model_regs[rt];
            endcase
        end
        put(r_word(func, rs, rt, rd));
    endtask

    task automatic emit_wwd(input int rs);
        if (!skipping)
            exp_out.push_back(model_regs[rs]);
        put(r_word(fn_wwd, rs, 0, 0));
    endtask

    task automatic emit_hlt();
        put(r_word(fn_hlt, 0, 0, 0));
    endtask

    task automatic emit_swd(input int rt, input int rs, input logic [7:0] imm);
        if (!skipping)
            stored[model_regs[rs] + sext(imm)] = model_regs[rt];
        put({op_swd, rs[1:0], rt[1:0], imm});
    endtask

    task automatic emit_lwd(input int rt, input int rs, input logic [7:0] imm);
        logic [15:0] addr;
        addr = model_regs[rs] + sext(imm);
        if (!skipping) begin
            model_regs[rt] = stored.exists(addr) ? stored[addr] : fill_word(addr);
            exp_loads++;
        end
        put({op_lwd, rs[1:0], rt[1:0], imm});
    endtask

    // the next skip words form the branch shadow skipped when taken
    task automatic emit_branch(input bit eq, input int rs, input int rt, input int skip);
        bit taken;
        taken = (model_regs[rs] == model_regs[rt]) == eq;
        put({eq ? op_beq : op_bne, rs[1:0], rt[1:0], skip[7:0]});
        skipping  = taken;
        skip_left = skip;
    endtask

    task automatic emit_jmp(input int skip);
        int target;
        target = prog.size() + 1 + skip;
        put({op_jmp, target[11:0]});
        skipping  = 1;
        skip_left = skip;
    endtask

    task automatic run_program();
        logic [15:0] a;
        for (int i = 0; i < 65536; i++) begin
            a = i[15:0];
            mem_i.imem[i] = ~fill_word(a);
            mem_i.dmem[i] = fill_word(a);
        end
        foreach (prog[i])
            mem_i.imem[i] = prog[i];
        @(negedge clk);
        reset = 1'b1;
        repeat (8) @(negedge clk);
        check_value("output_valid in reset", output_valid, 0);
        check_value("halted in reset", halted, 0);
        check_value("data_write in reset", data_write, 0);
        check_value("data_read in reset", data_read, 0);
        check_value("inst_read in reset", inst_read, 0);
        check_value("num_inst in reset", num_inst, 0);
        reset = 1'b0;
        got_out.delete();
        got_loads = 0;
        do begin
            @(negedge clk);
            if (output_valid)
                got_out.push_back(output_port);
            if (data_read)
                got_loads++;
        end while (!halted);
        repeat (4) begin   // pipeline must stay quiet
            @(negedge clk);
            check_value("output_valid after halt", output_valid, 0);
            check_value("inst_read after halt", inst_read, 0);
        end
        check_value("number of wwd outputs", got_out.size(), exp_out.size());
        foreach (exp_out[i])
            check_value($sformatf("wwd output %0d", i), got_out[i], exp_out[i]);
        check_value("number of loads", got_loads, exp_loads);
        check_value("num_inst", num_inst, exp_count);
        foreach (stored[k])
            check_value($sformatf("data memory word %0h", k), mem_i.dmem[k], stored[k]);
    endtask

    task automatic test_arith();
        logic [15:0] x;
        logic [15:0] y;
        logic [7:0]  k;
        start_program();
        for (int round = 0; round < 2; round++) begin
            x = 16'($random(seed));
            y = 16'($random(seed));
            k = 8'($random(seed));
            emit_const(0, x);
            emit_const(1, y);
            emit_alu(fn_add, 2, 0, 1);
            emit_wwd(2);
            emit_alu(fn_sub, 3, 0, 1);
            emit_wwd(3);
            emit_alu(fn_and, 2, 1, 0);
            emit_wwd(2);
            emit_alu(fn_orr, 3, 0, 1);
            emit_wwd(3);
            emit_adi(2, 0, k);
            emit_wwd(2);
            emit_lhi(3, k);
            emit_wwd(3);
        end
        emit_hlt();
        run_program();
    endtask

    task automatic test_raw();
        start_program();
        emit_const(0, 16'h1234);
        emit_adi(1, 0, 8'h05);
        emit_alu(fn_add, 2, 1, 0);
        emit_alu(fn_sub, 3, 2, 1);
        emit_wwd(3);
        emit_alu(fn_orr, 0, 3, 2);
        emit_adi(0, 0, 8'hf0);   // negative immediate
        emit_wwd(0);
        emit_adi(2, 3, 8'h11);
        emit_wwd(3);             // one slot between producer and user
        emit_wwd(2);
        emit_alu(fn_and, 1, 0, 3);
        emit_alu(fn_add, 1, 1, 1);
        emit_wwd(1);
        emit_hlt();
        run_program();
    endtask

    task automatic test_load_store();
        start_program();
        emit_const(0, 16'h0040);
        emit_const(1, 16'hbeef);
        emit_swd(1, 0, 8'h03);
        emit_lwd(2, 0, 8'h03);
        emit_wwd(2);             // load-use
        emit_adi(3, 2, 8'h01);
        emit_swd(3, 0, 8'hfe);   // base minus two
        emit_lwd(1, 0, 8'hfe);
        emit_alu(fn_add, 2, 1, 0);
        emit_wwd(2);
        emit_lwd(3, 0, 8'h10);   // never stored
        emit_wwd(3);
        emit_hlt();
        run_program();
    endtask

    task automatic test_branches();
        start_program();
        emit_const(0, 16'h0007);
        emit_const(1, 16'h0007);
        emit_const(2, 16'h0100);
        emit_branch(1, 0, 1, 2);   // beq taken
        emit_wwd(2);
        emit_wwd(2);
        emit_wwd(0);
        emit_branch(0, 0, 1, 1);   // bne not taken
        emit_adi(3, 0, 8'h01);
        emit_wwd(3);
        emit_branch(0, 0, 2, 3);   // bne taken
        emit_wwd(2);
        emit_wwd(1);
        emit_adi(0, 0, 8'h01);
        emit_branch(1, 3, 2, 1);   // beq not taken
        emit_wwd(2);
        emit_jmp(2);
        emit_wwd(1);
        emit_wwd(1);
        emit_wwd(3);
        emit_wwd(0);
        emit_hlt();
        run_program();
    endtask

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        seed  = 32'h2a58;
        test_arith();
        test_raw();
        test_load_store();
        test_branches();
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/tb_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_memory import cpu_isa_pkg::*; (
    input  logic                 clk,
    input  logic [word_size-1:0] inst_addr,
    output logic [word_size-1:0] inst_data,
    input  logic                 data_write,
    input  logic [word_size-1:0] data_addr,
    input  logic [word_size-1:0] data_wdata,
    output logic [word_size-1:0] data_rdata
);

    // full 64k words on each side
    logic [word_size-1:0] imem [65536];
    logic [word_size-1:0] dmem [65536];

    assign inst_data  = imem[inst_addr];
    assign data_rdata = dmem[data_addr];   // no wait states

    always @(posedge clk) begin
        if (data_write)
            dmem[data_addr] <= data_wdata;
    end

endmodule

`default_nettype wire
